/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = tb_cpu_controller
FILELIST = build.f
OBJ_DIR  = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
design/ctrl_pkg.sv
design/instr_decoder.sv
design/exec_steps.sv
design/instr_sequencer.sv
design/cpu_controller.sv
tb/clock_gen.sv
tb/cpu_controller_assert.sv
tb/tb_cpu_controller.sv

/* design/cpu_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_controller
(
    input  wire              clk,
    input  wire              reset,
    input  wire              run,          // Level, sampled at instruction boundaries
    input  ctrl_pkg::instr_t instruction,  // From the external instruction register
    input  wire              compare_true, // From the external comparator
    output ctrl_pkg::ctrl_t  ctrl,
    output logic             instr_done,
    output logic             illegal
);

    ctrl_pkg::decoded_t decoded;
    ctrl_pkg::ctrl_t    exec_ctrl;
    logic               exec_start;
    logic               exec_last;

    // Fetch, increment, decode and execute ordering
    instr_sequencer i_instr_sequencer
    (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .exec_ctrl  (exec_ctrl),
        .exec_last  (exec_last),
        .exec_start (exec_start),
        .ctrl       (ctrl),
        .instr_done (instr_done)
    );

    instr_decoder i_instr_decoder
    (
        .instruction (instruction),
        .decoded     (decoded)
    );

    // Class specific execute steps
    exec_steps i_exec_steps
    (
        .clk          (clk),
        .reset        (reset),
        .exec_start   (exec_start),
        .decoded      (decoded),
        .compare_true (compare_true),
        .exec_ctrl    (exec_ctrl),
        .exec_last    (exec_last),
        .illegal      (illegal)
    );

endmodule

`default_nettype wire

/* design/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    ////////////////////
    // Instruction fields

    localparam int OPCODE_LSB   = 0;
    localparam int OPCODE_WIDTH = 7;
    localparam int FUNCT3_LSB   = 12;
    localparam int FUNCT3_WIDTH = 3;

    // Major opcodes of the supported RV32I classes
    localparam logic [OPCODE_WIDTH-1:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_ITYPE  = 7'b0010011;  // Arithmetic immediates
    localparam logic [OPCODE_WIDTH-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPCODE_WIDTH-1:0] OPC_JALR   = 7'b1100111;

    typedef logic [31:0] instr_t;

    ////////////////////
    // Encodings

    typedef enum logic [2:0] {
        CLASS_R,
        CLASS_I,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_ILLEGAL
    } op_class_t;

    typedef enum logic [1:0] {
        SIZE_NONE,                    // No memory access
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_t;

    // Next program counter source
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_sel_t;

    // Register file write data source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4                        // Link address
    } wb_sel_t;

    ////////////////////
    // Bundles

    typedef struct packed {
        op_class_t op_class;
        mem_size_t mem_size;
    } decoded_t;

    // One control word per cycle towards the datapath
    typedef struct packed {
        logic      ir_en;
        logic      pc_en;
        pc_sel_t   pc_sel;
        logic      alu_src;           // 1 selects the immediate
        logic      reg_write;
        wb_sel_t   wb_sel;
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
    } ctrl_t;

endpackage

`default_nettype wire

/* design/exec_steps.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_steps
(
    input  wire                clk,
    input  wire                reset,
    input  wire                exec_start,    // Pulse in the decode cycle
    input  ctrl_pkg::decoded_t decoded,
    input  wire                compare_true,
    output ctrl_pkg::ctrl_t    exec_ctrl,
    output logic               exec_last,
    output logic               illegal
);

    typedef enum logic [1:0] {
        STEP_IDLE,
        STEP_ONE,
        STEP_TWO                              // Load write back only
    } step_t;

    step_t                step;
    ctrl_pkg::op_class_t  class_q;
    ctrl_pkg::mem_size_t  size_q;
    logic                 taken_q;

    ////////////////////
    // Latch at start

    always_ff @(posedge clk)
    begin
        if (exec_start)
        begin
            class_q <= decoded.op_class;
            size_q  <= decoded.mem_size;
            taken_q <= compare_true;          // Branch outcome seen at decode
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            step <= STEP_IDLE;
        else
        begin
            case (step)
                STEP_IDLE:
                    if (exec_start)
                        step <= STEP_ONE;
                STEP_ONE:
                    step <= (class_q == ctrl_pkg::CLASS_LOAD) ? STEP_TWO : STEP_IDLE;
                default:
                    step <= STEP_IDLE;
            endcase
        end
    end

    ////////////////////
    // Class controls

    always_comb
    begin
        exec_ctrl = '0;
        if (step == STEP_ONE)
        begin
            case (class_q)
                ctrl_pkg::CLASS_R:
                begin
                    exec_ctrl.reg_write = 1'b1;
                    exec_ctrl.wb_sel    = ctrl_pkg::WB_ALU;
                end
                ctrl_pkg::CLASS_I:
                begin
                    exec_ctrl.reg_write = 1'b1;
                    exec_ctrl.alu_src   = 1'b1;
                    exec_ctrl.wb_sel    = ctrl_pkg::WB_ALU;
                end
                ctrl_pkg::CLASS_LOAD:
                begin
                    exec_ctrl.mem_read  = 1'b1;   // Address from base plus offset
                    exec_ctrl.mem_size  = size_q;
                    exec_ctrl.alu_src   = 1'b1;
                end
                ctrl_pkg::CLASS_STORE:
                begin
                    exec_ctrl.mem_write = 1'b1;
                    exec_ctrl.mem_size  = size_q;
                    exec_ctrl.alu_src   = 1'b1;
                end
                ctrl_pkg::CLASS_BRANCH:
                begin
                    exec_ctrl.pc_en  = taken_q;   // Not taken gives an empty word
                    exec_ctrl.pc_sel = taken_q ? ctrl_pkg::PC_BRANCH : ctrl_pkg::PC_PLUS4;
                end
                ctrl_pkg::CLASS_JAL, ctrl_pkg::CLASS_JALR:
                begin
                    exec_ctrl.reg_write = 1'b1;
                    exec_ctrl.wb_sel    = ctrl_pkg::WB_PC4;
                    exec_ctrl.pc_en     = 1'b1;
                    if (class_q == ctrl_pkg::CLASS_JALR)
                    begin
                        exec_ctrl.pc_sel  = ctrl_pkg::PC_JALR;
                        exec_ctrl.alu_src = 1'b1;
                    end
                    else
                        exec_ctrl.pc_sel = ctrl_pkg::PC_JAL;
                end
                default:
                    exec_ctrl = '0;               // Illegal has no side effects
            endcase
        end
        else if (step == STEP_TWO)
        begin
            // Write the loaded data back
            exec_ctrl.reg_write = 1'b1;
            exec_ctrl.wb_sel    = ctrl_pkg::WB_MEM;
            exec_ctrl.alu_src   = 1'b1;
        end
    end

    assign exec_last = (step == STEP_TWO) ||
                       ((step == STEP_ONE) && (class_q != ctrl_pkg::CLASS_LOAD));
    assign illegal   = (step == STEP_ONE) && (class_q == ctrl_pkg::CLASS_ILLEGAL);

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
(
    input  ctrl_pkg::instr_t   instruction,
    output ctrl_pkg::decoded_t decoded
);

    logic [ctrl_pkg::OPCODE_WIDTH-1:0] opcode;
    logic [ctrl_pkg::FUNCT3_WIDTH-1:0] funct3;

    assign opcode = instruction[ctrl_pkg::OPCODE_LSB +: ctrl_pkg::OPCODE_WIDTH];
    assign funct3 = instruction[ctrl_pkg::FUNCT3_LSB +: ctrl_pkg::FUNCT3_WIDTH];

    always_comb
    begin
        // Anything not matched below stays illegal
        decoded.op_class = ctrl_pkg::CLASS_ILLEGAL;
        decoded.mem_size = ctrl_pkg::SIZE_NONE;
        case (opcode)
            ctrl_pkg::OPC_RTYPE:  decoded.op_class = ctrl_pkg::CLASS_R;
            ctrl_pkg::OPC_ITYPE:  decoded.op_class = ctrl_pkg::CLASS_I;
            ctrl_pkg::OPC_BRANCH: decoded.op_class = ctrl_pkg::CLASS_BRANCH;
            ctrl_pkg::OPC_JAL:    decoded.op_class = ctrl_pkg::CLASS_JAL;
            ctrl_pkg::OPC_JALR:   decoded.op_class = ctrl_pkg::CLASS_JALR;
            ctrl_pkg::OPC_LOAD:
            begin
                decoded.op_class = ctrl_pkg::CLASS_LOAD;
                case (funct3)
                    3'd0, 3'd4: decoded.mem_size = ctrl_pkg::SIZE_BYTE;  // LB, LBU
                    3'd1, 3'd5: decoded.mem_size = ctrl_pkg::SIZE_HALF;  // LH, LHU
                    3'd2:       decoded.mem_size = ctrl_pkg::SIZE_WORD;
                    default:    decoded.op_class = ctrl_pkg::CLASS_ILLEGAL;
                endcase
            end
            ctrl_pkg::OPC_STORE:
            begin
                decoded.op_class = ctrl_pkg::CLASS_STORE;
                case (funct3)
                    3'd0:    decoded.mem_size = ctrl_pkg::SIZE_BYTE;
                    3'd1:    decoded.mem_size = ctrl_pkg::SIZE_HALF;
                    3'd2:    decoded.mem_size = ctrl_pkg::SIZE_WORD;
                    default: decoded.op_class = ctrl_pkg::CLASS_ILLEGAL;
                endcase
            end
            default:
                decoded.op_class = ctrl_pkg::CLASS_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

/* design/instr_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_sequencer
(
    input  wire             clk,
    input  wire             reset,
    input  wire             run,
    input  ctrl_pkg::ctrl_t exec_ctrl,
    input  wire             exec_last,
    output logic            exec_start,
    output ctrl_pkg::ctrl_t ctrl,
    output logic            instr_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_INCR,
        ST_DECODE,
        ST_EXEC
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;

    ////////////////////
    // State machine

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
                if (run)
                    state_next = ST_FETCH;
            ST_FETCH:  state_next = ST_INCR;
            ST_INCR:   state_next = ST_DECODE;
            ST_DECODE: state_next = ST_EXEC;
            ST_EXEC:
            begin
                // Run only matters at the instruction boundary
                if (exec_last)
                    state_next = run ? ST_FETCH : ST_IDLE;
            end
            default:   state_next = ST_IDLE;
        endcase
    end

    ////////////////////
    // Control word merge

    always_comb
    begin
        ctrl = '0;
        case (state)
            ST_FETCH:
                ctrl.ir_en = 1'b1;          // Load the instruction register
            ST_INCR:
            begin
                ctrl.pc_en  = 1'b1;
                ctrl.pc_sel = ctrl_pkg::PC_PLUS4;
            end
            ST_EXEC:
                ctrl = exec_ctrl;           // Execute steps own the word here
            default:
                ctrl = '0;
        endcase
    end

    assign exec_start = (state == ST_DECODE);
    assign instr_done = (state == ST_EXEC) && exec_last;

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen
#(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 5
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);         // Release away from the active edge
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tb/cpu_controller_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_controller_assert
(
    input wire             clk,
    input wire             reset,
    input ctrl_pkg::ctrl_t ctrl,
    input wire             instr_done
);

    int violations = 0;     // Read by the testbench at the end

    // At most one datapath strobe per cycle
    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.ir_en, ctrl.pc_en, ctrl.mem_read, ctrl.mem_write}))
    else
    begin
        violations = violations + 1;
        $error("Control strobes overlap in word %h", ctrl);
    end

    done_single: assert property (@(posedge clk) disable iff (reset)
        instr_done |=> !instr_done)
    else
    begin
        violations = violations + 1;
        $error("instr_done high on two consecutive cycles");
    end

    // A memory access always carries its width
    size_on_access: assert property (@(posedge clk) disable iff (reset)
        (ctrl.mem_read || ctrl.mem_write) |-> (ctrl.mem_size != ctrl_pkg::SIZE_NONE))
    else
    begin
        violations = violations + 1;
        $error("Memory access without a size in word %h", ctrl);
    end

endmodule

`default_nettype wire

/* tb/tb_cpu_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_controller;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_DIRECT   = 17;
    localparam int NUM_RANDOM   = 24;
    localparam int NUM_INSTR    = NUM_DIRECT + NUM_RANDOM;
    localparam int PAD_CYCLES   = 20;               // Idle stretches at start and end

    logic             clk;
    logic             reset;
    logic             run;
    ctrl_pkg::instr_t instruction;
    logic             compare_true;
    ctrl_pkg::ctrl_t  ctrl;
    logic             instr_done;
    logic             illegal;

    // Instructions handed to the DUT, consumed at fetch
    ctrl_pkg::instr_t instr_q[$];
    logic             cmp_q[$];
    string            name_q[$];

    logic [31:0]      lfsr_state;
    int               mismatches = 0;
    int               other_errors = 0;
    int               checks = 0;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen
    (
        .clk   (clk),
        .reset (reset)
    );

    cpu_controller i_cpu_controller
    (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .instruction  (instruction),
        .compare_true (compare_true),
        .ctrl         (ctrl),
        .instr_done   (instr_done),
        .illegal      (illegal)
    );

    bind cpu_controller cpu_controller_assert i_cpu_controller_assert
    (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .instr_done (instr_done)
    );

    ////////////////////
    // Random source

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [ctrl_pkg::OPCODE_WIDTH-1:0] pick_opcode(input logic [2:0] idx);
        case (idx)
            3'd0:    return ctrl_pkg::OPC_RTYPE;
            3'd1:    return ctrl_pkg::OPC_ITYPE;
            3'd2:    return ctrl_pkg::OPC_LOAD;
            3'd3:    return ctrl_pkg::OPC_STORE;
            3'd4:    return ctrl_pkg::OPC_BRANCH;
            3'd5:    return ctrl_pkg::OPC_JAL;
            3'd6:    return ctrl_pkg::OPC_JALR;
            default: return 7'(rand_bits(7));   // Mostly unknown opcodes
        endcase
    endfunction

    ////////////////////
    // Reference model

    // Expected word for one cycle of an instruction, step 0 being fetch
    function automatic ctrl_pkg::ctrl_t expect_ctrl(input ctrl_pkg::instr_t instr,
                                                    input logic cmp, input int step,
                                                    output int steps,
                                                    output logic exp_illegal);
        logic [ctrl_pkg::OPCODE_WIDTH-1:0] opc;
        logic [ctrl_pkg::FUNCT3_WIDTH-1:0] f3;
        ctrl_pkg::op_class_t               cls;
        ctrl_pkg::mem_size_t               size;
        ctrl_pkg::ctrl_t                   w;

        opc  = instr[ctrl_pkg::OPCODE_LSB +: ctrl_pkg::OPCODE_WIDTH];
        f3   = instr[ctrl_pkg::FUNCT3_LSB +: ctrl_pkg::FUNCT3_WIDTH];
        cls  = ctrl_pkg::CLASS_ILLEGAL;
        size = ctrl_pkg::SIZE_NONE;
        // Width comes from the low funct3 bits
        if (opc == ctrl_pkg::OPC_LOAD && f3[1:0] != 2'd3 && f3 != 3'd6)
        begin
            cls  = ctrl_pkg::CLASS_LOAD;
            size = ctrl_pkg::mem_size_t'(f3[1:0] + 2'd1);
        end
        else if (opc == ctrl_pkg::OPC_STORE && !f3[2] && f3[1:0] != 2'd3)
        begin
            cls  = ctrl_pkg::CLASS_STORE;
            size = ctrl_pkg::mem_size_t'(f3[1:0] + 2'd1);
        end
        else if (opc == ctrl_pkg::OPC_RTYPE)
            cls = ctrl_pkg::CLASS_R;
        else if (opc == ctrl_pkg::OPC_ITYPE)
            cls = ctrl_pkg::CLASS_I;
        else if (opc == ctrl_pkg::OPC_BRANCH)
            cls = ctrl_pkg::CLASS_BRANCH;
        else if (opc == ctrl_pkg::OPC_JAL)
            cls = ctrl_pkg::CLASS_JAL;
        else if (opc == ctrl_pkg::OPC_JALR)
            cls = ctrl_pkg::CLASS_JALR;

        w = '0;
        exp_illegal = 1'b0;
        steps = (cls == ctrl_pkg::CLASS_LOAD) ? 5 : 4;   // Fetch, increment, decode, execute
        if (step == 0)
            w.ir_en = 1'b1;
        else if (step == 1)
        begin
            w.pc_en  = 1'b1;
            w.pc_sel = ctrl_pkg::PC_PLUS4;
        end
        else if (step >= 3)
        begin
            case (cls)
                ctrl_pkg::CLASS_R, ctrl_pkg::CLASS_I:
                begin
                    w.reg_write = 1'b1;
                    w.alu_src   = (cls == ctrl_pkg::CLASS_I);
                    w.wb_sel    = ctrl_pkg::WB_ALU;
                end
                ctrl_pkg::CLASS_LOAD:
                begin
                    w.alu_src = 1'b1;
                    if (step == 3)
                    begin
                        w.mem_read = 1'b1;
                        w.mem_size = size;
                    end
                    else
                    begin
                        w.reg_write = 1'b1;
                        w.wb_sel    = ctrl_pkg::WB_MEM;
                    end
                end
                ctrl_pkg::CLASS_STORE:
                begin
                    w.mem_write = 1'b1;
                    w.mem_size  = size;
                    w.alu_src   = 1'b1;
                end
                ctrl_pkg::CLASS_BRANCH:
                begin
                    if (cmp)
                    begin
                        w.pc_en  = 1'b1;
                        w.pc_sel = ctrl_pkg::PC_BRANCH;
                    end
                end
                ctrl_pkg::CLASS_JAL, ctrl_pkg::CLASS_JALR:
                begin
                    w.reg_write = 1'b1;
                    w.wb_sel    = ctrl_pkg::WB_PC4;
                    w.pc_en     = 1'b1;
                    w.pc_sel    = (cls == ctrl_pkg::CLASS_JAL) ? ctrl_pkg::PC_JAL
                                                               : ctrl_pkg::PC_JALR;
                    w.alu_src   = (cls == ctrl_pkg::CLASS_JALR);
                end
                default:
                    exp_illegal = 1'b1;
            endcase
        end
        return w;
    endfunction

    ////////////////////
    // Checks

    task automatic check_ctrl(input string name, input ctrl_pkg::ctrl_t exp,
                              input ctrl_pkg::ctrl_t act);
        checks++;
        if (act !== exp)
        begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            mismatches++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    ////////////////////
    // Stimulus helpers

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        while (instr_done !== 1'b1 && cycles < 16);
        if (instr_done !== 1'b1)
        begin
            other_errors++;
            $display("Instruction %s never signalled instr_done", name);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            run = 1'b0;
        end
    endtask

    // Keep_run low drops run during fetch so the unit idles afterwards
    task automatic issue(input string name, input logic [ctrl_pkg::OPCODE_WIDTH-1:0] opcode,
                         input logic [ctrl_pkg::FUNCT3_WIDTH-1:0] funct3, input logic cmp,
                         input logic keep_run);
        ctrl_pkg::instr_t instr;
        instr = rand_bits(32);
        instr[ctrl_pkg::OPCODE_LSB +: ctrl_pkg::OPCODE_WIDTH] = opcode;
        instr[ctrl_pkg::FUNCT3_LSB +: ctrl_pkg::FUNCT3_WIDTH] = funct3;
        @(negedge clk);
        instruction  = instr;       // Held until the instruction is done
        compare_true = !cmp;        // Only the decode edge sees cmp
        run          = 1'b1;
        instr_q.push_back(instr);
        cmp_q.push_back(cmp);
        name_q.push_back(name);
        @(negedge clk);             // Fetch cycle
        if (!keep_run)
            run = 1'b0;
        repeat (2) @(negedge clk);  // Increment, then decode
        compare_true = cmp;
        wait_done(name);
        if (!keep_run)
            @(negedge clk);
    endtask

    ////////////////////
    // Compare process

    initial
    begin : compare_outputs
        logic             busy;
        int               step;
        int               steps;
        ctrl_pkg::instr_t cur_instr;
        logic             cur_cmp;
        string            cur_name;
        string            label;
        ctrl_pkg::ctrl_t  exp_ctrl;
        logic             exp_illegal;
        logic             exp_done;

        busy  = 1'b0;
        step  = 0;
        steps = 0;
        wait (reset === 1'b0);
        forever
        begin
            @(posedge clk);
            #1;
            // Run still holds the value seen at this edge
            if (busy && step < steps - 1)
                step = step + 1;
            else if (run)
            begin
                if (instr_q.size() == 0)
                begin
                    other_errors++;
                    $display("Run was high with no instruction queued");
                    busy = 1'b0;
                end
                else
                begin
                    busy      = 1'b1;
                    step      = 0;
                    cur_instr = instr_q.pop_front();
                    cur_cmp   = cmp_q.pop_front();
                    cur_name  = name_q.pop_front();
                end
            end
            else
                busy = 1'b0;

            if (busy)
            begin
                exp_ctrl = expect_ctrl(cur_instr, cur_cmp, step, steps, exp_illegal);
                exp_done = (step == steps - 1);
                label    = $sformatf("%s step %0d", cur_name, step);
            end
            else
            begin
                exp_ctrl    = '0;
                exp_illegal = 1'b0;
                exp_done    = 1'b0;
                label       = "idle";
            end
            check_ctrl({label, " ctrl"}, exp_ctrl, ctrl);
            check_bit({label, " instr_done"}, exp_done, instr_done);
            check_bit({label, " illegal"}, exp_illegal, illegal);
        end
    end

    ////////////////////
    // Main sequence

    initial
    begin : stimulus
        int asserts;

        run          = 1'b0;
        instruction  = '0;
        compare_true = 1'b0;
        lfsr_state   = 32'd32089;
        wait (reset === 1'b0);
        idle_cycles(8);                             // Run low after reset

        issue("r_type", ctrl_pkg::OPC_RTYPE, 3'd0, 1'b0, 1'b0);
        issue("i_type", ctrl_pkg::OPC_ITYPE, 3'd5, 1'b1, 1'b0);
        issue("load_lb", ctrl_pkg::OPC_LOAD, 3'd0, 1'b0, 1'b0);
        issue("load_lh", ctrl_pkg::OPC_LOAD, 3'd1, 1'b0, 1'b0);
        issue("load_lw", ctrl_pkg::OPC_LOAD, 3'd2, 1'b1, 1'b0);
        issue("load_lbu", ctrl_pkg::OPC_LOAD, 3'd4, 1'b0, 1'b0);
        issue("load_lhu", ctrl_pkg::OPC_LOAD, 3'd5, 1'b0, 1'b0);
        issue("store_sb", ctrl_pkg::OPC_STORE, 3'd0, 1'b0, 1'b0);
        issue("store_sh", ctrl_pkg::OPC_STORE, 3'd1, 1'b1, 1'b0);
        issue("store_sw", ctrl_pkg::OPC_STORE, 3'd2, 1'b0, 1'b0);
        issue("branch_taken", ctrl_pkg::OPC_BRANCH, 3'd0, 1'b1, 1'b0);
        issue("branch_not_taken", ctrl_pkg::OPC_BRANCH, 3'd1, 1'b0, 1'b0);
        issue("jal", ctrl_pkg::OPC_JAL, 3'd3, 1'b0, 1'b0);
        issue("jalr", ctrl_pkg::OPC_JALR, 3'd0, 1'b1, 1'b0);
        issue("unknown_opcode", 7'h7f, 3'd0, 1'b0, 1'b0);
        issue("load_funct3_3", ctrl_pkg::OPC_LOAD, 3'd3, 1'b0, 1'b0);
        issue("store_funct3_4", ctrl_pkg::OPC_STORE, 3'd4, 1'b0, 1'b0);

        // Back to back with run held high
        for (int i = 0; i < NUM_RANDOM; i++)
            issue($sformatf("random_%0d", i), pick_opcode(3'(rand_bits(3))),
                  3'(rand_bits(3)), 1'(rand_bits(1)), 1'b1);
        idle_cycles(6);

        if (instr_q.size() != 0)
        begin
            other_errors++;
            $display("%0d queued instructions were never fetched", instr_q.size());
        end
        asserts = i_cpu_controller.i_cpu_controller_assert.violations;
        $display("Checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 checks, mismatches, other_errors, asserts);
        if (mismatches == 0 && other_errors == 0 && asserts == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Longest instruction plus its idle gap stays under 8 cycles
    initial
    begin : watchdog
        #((RESET_CYCLES + PAD_CYCLES + NUM_INSTR * 8) * CLK_PERIOD);
        $display("Timeout after %0d cycles, the test sequence did not complete",
                 RESET_CYCLES + PAD_CYCLES + NUM_INSTR * 8);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
